// File: verilog.f
verilog/isa_pkg.sv
verilog/lsb_pkg.sv
verilog/hazard_check.sv
verilog/slot_alloc.sv
verilog/long_scoreboard.sv
verilog/lsb_top.sv
bench/tb_lsb_top.sv

// File: run.sh
#!/bin/sh
# build the scoreboard testbench with Verilator and run it
# a $fatal in the testbench gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_lsb_top -f verilog.f -o tb_lsb_top &&
./obj_dir/tb_lsb_top ||
{ echo "simulation run failed"; exit 1; }

// File: bench/tb_lsb_top.sv
module tb_lsb_top
    import isa_pkg::*;
    import lsb_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 3;
    localparam int RANDOM_CYCLES = 2000;
    localparam int MAX_HOLD      = 4;   // a pair dependency never clears, redraw after this
    // a quarter on top of the random run covers reset and the directed part
    localparam int CYCLE_LIMIT   = (RANDOM_CYCLES * 5) / 4;

    logic        clk;
    logic        rst_n;
    issue_slot_t slot1;         // older instruction
    issue_slot_t slot2;         // younger instruction
    commit_t     commit;
    logic        stall_o;
    logic        waw_o;
    commit_id_t  slot1_id_o;
    commit_id_t  slot2_id_o;
    logic        atom_lock_o;

    integer      seed;
    int          stall_run;     // cycles the current pair has been held
    int          cycle_cnt = 0;
    commit_id_t  got_id;

    // dut outputs captured at each rising edge, read back at the falling edge
    logic        last_stall = 1'b0;
    logic        last_waw   = 1'b0;
    commit_id_t  last_id1   = '0;
    commit_id_t  last_id2   = '0;

    // behavioral copy of the table
    lsb_mask_t   model_valid;
    reg_addr_t   model_rd [LSB_DEPTH];

    // expected verdict for the pair at issue
    logic        exp_raw;
    logic        exp_waw;
    logic        exp_full;
    logic        exp_stall;
    logic        exp_ins1;
    logic        exp_ins2;
    commit_id_t  exp_id1;
    commit_id_t  exp_id2;
    commit_id_t  low_free;      // lowest clear model bit
    commit_id_t  next_free;     // next clear bit above it
    int          used;          // occupied model entries

    lsb_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .slot1_i     (slot1),
        .slot2_i     (slot2),
        .commit_i    (commit),
        .stall_o     (stall_o),
        .waw_o       (waw_o),
        .slot1_id_o  (slot1_id_o),
        .slot2_id_o  (slot2_id_o),
        .atom_lock_o (atom_lock_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        stop_with_failure($sformatf("ERR time=%0t %s expected=%0h actual=%0h",
                                    $time, name, exp, got));
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got == exp) else mismatch(name, exp, got);
    endtask

    // slot reads register r, x0 is never a dependency
    function automatic logic reads_reg(input issue_slot_t s, input reg_addr_t r);
        return s.valid && (r != '0) && ((s.rs1 == r) || (s.rs2 == r));
    endfunction

    // slot writes a real destination
    function automatic logic has_dest(input issue_slot_t s);
        return s.valid && s.rd_we && (s.rd != '0);
    endfunction

    // hazards against the table minus the retiring entry, then inside the pair
    always_comb begin
        exp_raw = 1'b0;
        exp_waw = 1'b0;
        for (int e = 0; e < LSB_DEPTH; e++) begin
            if (model_valid[e] && !(commit.valid && (int'(commit.id) == e))) begin
                if (reads_reg(slot1, model_rd[e]) || reads_reg(slot2, model_rd[e])) begin
                    exp_raw = 1'b1;
                end
                if ((has_dest(slot1) && (slot1.rd == model_rd[e])) ||
                    (has_dest(slot2) && (slot2.rd == model_rd[e]))) begin
                    exp_waw = 1'b1;
                end
            end
        end
        if (has_dest(slot2) && reads_reg(slot1, slot2.rd)) begin
            exp_raw = 1'b1;
        end
        if (has_dest(slot1) && reads_reg(slot2, slot1.rd)) begin
            exp_raw = 1'b1;
        end
        if (has_dest(slot1) && has_dest(slot2) && (slot1.rd == slot2.rd)) begin
            exp_waw = 1'b1;
        end
    end

    // free entries, acceptance and the ids that should come back
    always_comb begin
        used      = 0;
        low_free  = '0;
        next_free = '0;
        for (int e = LSB_DEPTH - 1; e >= 0; e--) begin
            if (model_valid[e]) begin
                used = used + 1;
            end else begin
                next_free = low_free;   // previous lowest becomes the runner-up
                low_free  = commit_id_t'(e);
            end
        end
        exp_full  = (used == LSB_DEPTH);
        exp_stall = exp_raw || exp_full;
        exp_ins1  = !exp_stall && slot1.valid;
        exp_ins2  = !exp_stall && slot2.valid && (used + 2 <= LSB_DEPTH);  // room for two
        exp_id1   = exp_ins1 ? low_free : '0;
        exp_id2   = '0;
        if (exp_ins2) begin
            exp_id2 = slot1.valid ? next_free : low_free;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_valid <= '0;
        end else begin
            if (commit.valid) begin
                model_valid[commit.id] <= 1'b0;
            end
            if (exp_ins1) begin
                model_valid[exp_id1] <= 1'b1;
                model_rd[exp_id1]    <= slot1.rd;
            end
            if (exp_ins2) begin
                model_valid[exp_id2] <= 1'b1;
                model_rd[exp_id2]    <= slot2.rd;
            end
        end
    end

    always @(posedge clk) begin
        last_stall <= stall_o;
        last_waw   <= waw_o;
        last_id1   <= slot1_id_o;
        last_id2   <= slot2_id_o;
    end

    stall_matches: assert property (@(posedge clk) disable iff (!rst_n) stall_o == exp_stall)
        else mismatch("stall_o", 32'(exp_stall), 32'(stall_o));
    waw_matches: assert property (@(posedge clk) disable iff (!rst_n) waw_o == exp_waw)
        else mismatch("waw_o", 32'(exp_waw), 32'(waw_o));
    id1_matches: assert property (@(posedge clk) disable iff (!rst_n) slot1_id_o == exp_id1)
        else mismatch("slot1_id_o", 32'(exp_id1), 32'(slot1_id_o));
    id2_matches: assert property (@(posedge clk) disable iff (!rst_n) slot2_id_o == exp_id2)
        else mismatch("slot2_id_o", 32'(exp_id2), 32'(slot2_id_o));
    lock_matches: assert property (@(posedge clk) disable iff (!rst_n)
                                   atom_lock_o == (|model_valid))
        else mismatch("atom_lock_o", 32'(|model_valid), 32'(atom_lock_o));

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("timeout, run still busy after %0d cycles",
                                        CYCLE_LIMIT));
        end
    end

    task automatic set_idle();
        slot1  = '0;
        slot2  = '0;
        commit = '0;
    endtask

    // registers 0..7 only, so collisions come often
    task automatic draw_slots();
        logic [31:0] r;
        r = $random(seed);
        slot1.valid = |r[1:0];     // about three in four
        slot1.rd_we = |r[3:2];
        slot1.rd    = {2'b00, r[6:4]};
        slot1.rs1   = {2'b00, r[9:7]};
        slot1.rs2   = {2'b00, r[12:10]};
        slot2.valid = |r[14:13];
        slot2.rd_we = |r[16:15];
        slot2.rd    = {2'b00, r[19:17]};
        slot2.rs1   = {2'b00, r[22:20]};
        slot2.rs2   = {2'b00, r[25:23]};
    endtask

    // retire a random occupied entry, scan starts at a random index
    task automatic draw_commit();
        logic [31:0] r;
        int          e;
        r = $random(seed);
        commit = '0;
        if (r[1:0] != 2'b00) begin
            for (int k = 0; k < LSB_DEPTH; k++) begin
                e = (int'(r[4:2]) + k) % LSB_DEPTH;
                if (model_valid[e] && !commit.valid) begin
                    commit.valid = 1'b1;
                    commit.id    = commit_id_t'(e);
                end
            end
        end
    endtask

    // commit the lowest occupied entry each cycle until the table is empty
    task automatic drain_table();
        while (model_valid != '0) begin
            commit = '0;
            for (int e = LSB_DEPTH - 1; e >= 0; e--) begin
                if (model_valid[e]) begin
                    commit.valid = 1'b1;
                    commit.id    = commit_id_t'(e);
                end
            end
            @(negedge clk);
        end
        commit = '0;
    endtask

    // hold the pair until an edge without stall, returns the slot 1 id
    task automatic wait_accept(output commit_id_t id);
        do begin
            @(negedge clk);
        end while (last_stall);
        id = last_id1;
    endtask

    // one long op in slot 1, sources x0 so only a full table can stall it
    task automatic issue_single(input reg_addr_t rd, output commit_id_t id);
        slot1       = '0;
        slot1.valid = 1'b1;
        slot1.rd_we = 1'b1;
        slot1.rd    = rd;
        slot2       = '0;
        wait_accept(id);
    endtask

    initial begin
        seed      = 32'hb70e5a3f;
        stall_run = 0;
        rst_n     = 1'b0;
        set_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);             // one edge with idle inputs
        check_value("stall_o", 32'd0, 32'(last_stall));
        check_value("waw_o", 32'd0, 32'(last_waw));
        check_value("slot1_id_o", 32'd0, 32'(last_id1));
        check_value("slot2_id_o", 32'd0, 32'(last_id2));
        check_value("atom_lock_o", 32'd0, 32'(atom_lock_o));

        repeat (RANDOM_CYCLES) begin
            if (last_stall && (stall_run < MAX_HOLD)) begin
                stall_run = stall_run + 1;     // upstream holds the pair
            end else begin
                stall_run = 0;
                draw_slots();
            end
            draw_commit();                     // commits go on during a stall
            @(negedge clk);
        end

        set_idle();
        drain_table();
        check_value("atom_lock_o", 32'd0, 32'(atom_lock_o));   // fell after last commit

        // fill all eight entries, empty table hands out ids in order
        for (int k = 0; k < LSB_DEPTH; k++) begin
            issue_single(reg_addr_t'(k + 1), got_id);
            check_value("slot1_id_o", 32'(k), 32'(got_id));
        end
        slot1.rd = reg_addr_t'(LSB_DEPTH + 1);  // ninth op, no free entry
        @(negedge clk);
        check_value("stall_o", 32'd1, 32'(last_stall));
        commit = '{valid: 1'b1, id: commit_id_t'(3)};
        @(negedge clk);
        commit = '0;
        wait_accept(got_id);
        check_value("slot1_id_o", 32'd3, 32'(got_id));   // reuses the freed entry

        // x2 still in flight at entry 1, rewriting it is a flag only
        set_idle();
        commit = '{valid: 1'b1, id: commit_id_t'(0)};
        @(negedge clk);
        commit = '0;
        issue_single(reg_addr_t'(2), got_id);
        check_value("waw_o", 32'd1, 32'(last_waw));
        check_value("slot1_id_o", 32'd0, 32'(got_id));

        // seven in flight, slot 2 of the pair gets no entry
        set_idle();
        commit = '{valid: 1'b1, id: commit_id_t'(5)};
        @(negedge clk);
        commit = '0;
        slot1 = '{valid: 1'b1, rd_we: 1'b1, rd: reg_addr_t'(10), rs1: REG_X0, rs2: REG_X0};
        slot2 = '{valid: 1'b1, rd_we: 1'b1, rd: reg_addr_t'(11), rs1: REG_X0, rs2: REG_X0};
        wait_accept(got_id);
        check_value("slot1_id_o", 32'd5, 32'(got_id));
        check_value("slot2_id_o", 32'd0, 32'(last_id2));

        set_idle();
        drain_table();
        check_value("atom_lock_o", 32'd0, 32'(atom_lock_o));
        repeat (2) @(negedge clk);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: verilog/lsb_top.sv
module lsb_top
    import isa_pkg::*;
    import lsb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  issue_slot_t slot1_i,      // older of the pair
    input  issue_slot_t slot2_i,      // younger of the pair
    input  commit_t     commit_i,
    output logic        stall_o,
    output logic        waw_o,
    output commit_id_t  slot1_id_o,
    output commit_id_t  slot2_id_o,
    output logic        atom_lock_o
);

    lsb_mask_t  mask;       // table valid bits
    rd_tab_t    rd_tab;     // table destinations
    hazard_t    verdict;
    commit_id_t first_id;
    commit_id_t second_id;
    logic       full;
    logic       two_ok;

    hazard_check i_hazard_check (
        .slot1_i   (slot1_i),
        .slot2_i   (slot2_i),
        .commit_i  (commit_i),
        .mask_i    (mask),
        .rd_tab_i  (rd_tab),
        .verdict_o (verdict)
    );

    slot_alloc i_slot_alloc (
        .mask_i        (mask),
        .slot1_valid_i (slot1_i.valid),
        .slot2_valid_i (slot2_i.valid),
        .first_id_o    (first_id),
        .second_id_o   (second_id),
        .full_o        (full),
        .two_ok_o      (two_ok)
    );

    long_scoreboard i_long_scoreboard (
        .clk         (clk),
        .rst_n       (rst_n),
        .slot1_i     (slot1_i),
        .slot2_i     (slot2_i),
        .commit_i    (commit_i),
        .verdict_i   (verdict),
        .first_id_i  (first_id),
        .second_id_i (second_id),
        .full_i      (full),
        .two_ok_i    (two_ok),
        .mask_o      (mask),
        .rd_tab_o    (rd_tab),
        .stall_o     (stall_o),
        .waw_o       (waw_o),
        .slot1_id_o  (slot1_id_o),
        .slot2_id_o  (slot2_id_o),
        .atom_lock_o (atom_lock_o)
    );

endmodule

// File: verilog/long_scoreboard.sv
module long_scoreboard
    import isa_pkg::*;
    import lsb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  issue_slot_t slot1_i,
    input  issue_slot_t slot2_i,
    input  commit_t     commit_i,      // frees one entry at the edge
    input  hazard_t     verdict_i,
    input  commit_id_t  first_id_i,
    input  commit_id_t  second_id_i,
    input  logic        full_i,
    input  logic        two_ok_i,
    output lsb_mask_t   mask_o,
    output rd_tab_t     rd_tab_o,
    output logic        stall_o,
    output logic        waw_o,
    output commit_id_t  slot1_id_o,
    output commit_id_t  slot2_id_o,
    output logic        atom_lock_o    // any long op still in flight
);

    lsb_mask_t mask_q;     // entry valid bits
    lsb_mask_t mask_d;
    rd_tab_t   rd_tab_q;   // destination of each entry

    logic accept;          // pair leaves issue this cycle
    logic ins1;            // slot 1 goes into the table
    logic ins2;            // slot 2 goes into the table

    // only true dependencies and a full table hold the pair
    assign stall_o = verdict_i.raw | full_i;
    assign accept  = ~stall_o;
    assign waw_o   = verdict_i.waw;  // reported, never stalls

    assign ins1 = accept && slot1_i.valid;
    assign ins2 = accept && slot2_i.valid && two_ok_i;  // needs two free entries

    assign slot1_id_o = ins1 ? first_id_i : '0;
    assign slot2_id_o = ins2 ? second_id_i : '0;

    // next mask, commit clear first so a same-edge insert still sets
    always_comb begin
        mask_d = mask_q;
        if (commit_i.valid) begin
            mask_d[commit_i.id] = 1'b0;
        end
        if (ins1) begin
            mask_d[first_id_i] = 1'b1;
        end
        if (ins2) begin
            mask_d[second_id_i] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '0;  // empty table
        end else begin
            mask_q <= mask_d;
        end
    end

    // destination captured with each insertion
    always_ff @(posedge clk) begin
        if (ins1) begin
            rd_tab_q[first_id_i] <= slot1_i.rd;
        end
        if (ins2) begin
            rd_tab_q[second_id_i] <= slot2_i.rd;
        end
    end

    assign mask_o      = mask_q;
    assign rd_tab_o    = rd_tab_q;
    assign atom_lock_o = |mask_q;

endmodule

// File: verilog/slot_alloc.sv
module slot_alloc
    import lsb_pkg::*;
(
    input  lsb_mask_t  mask_i,         // occupied entries
    input  logic       slot1_valid_i,
    input  logic       slot2_valid_i,
    output commit_id_t first_id_o,     // lowest free entry
    output commit_id_t second_id_o,    // entry for slot 2
    output logic       full_o,         // no entry left
    output logic       two_ok_o        // room for a whole pair
);

    logic [OCC_WIDTH-1:0] occ;         // entries in use
    commit_id_t           first_free;
    commit_id_t           next_free;   // lowest free entry past first_free
    logic                 pair_fits;   // both slots get their own entry

    // population count of the mask
    always_comb begin
        occ = '0;
        for (int i = 0; i < LSB_DEPTH; i++) begin
            occ = occ + OCC_WIDTH'(mask_i[i]);
        end
    end

    // scan downward so the lowest clear bit is written last
    always_comb begin
        first_free = '0;  // stays 0 when full
        for (int i = LSB_DEPTH - 1; i >= 0; i--) begin
            if (!mask_i[i]) begin
                first_free = commit_id_t'(i);
            end
        end
    end

    // same scan with first_free taken out
    always_comb begin
        next_free = '0;
        for (int i = LSB_DEPTH - 1; i >= 0; i--) begin
            if (!mask_i[i] && (commit_id_t'(i) != first_free)) begin
                next_free = commit_id_t'(i);
            end
        end
    end

    assign full_o   = &mask_i;
    assign two_ok_o = (occ <= OCC_WIDTH'(TWO_OK_MAX));

    assign pair_fits = slot1_valid_i && slot2_valid_i && two_ok_o;

    assign first_id_o = first_free;
    // a lone slot 2 simply takes the first free entry
    assign second_id_o = pair_fits ? next_free : first_free;

endmodule

// File: verilog/hazard_check.sv
module hazard_check
    import isa_pkg::*;
    import lsb_pkg::*;
(
    input  issue_slot_t slot1_i,    // older instruction
    input  issue_slot_t slot2_i,    // younger instruction
    input  commit_t     commit_i,
    input  lsb_mask_t   mask_i,     // occupied entries
    input  rd_tab_t     rd_tab_i,   // destination per entry
    output hazard_t     verdict_o
);

    // operand qualifiers, x0 and empty slots drop out here
    logic s1_rs1_chk;
    logic s1_rs2_chk;
    logic s1_rd_chk;
    logic s2_rs1_chk;
    logic s2_rs2_chk;
    logic s2_rd_chk;

    lsb_mask_t live;       // occupied and not retiring this cycle
    logic      raw_tab;    // either slot reads an in-flight rd
    logic      waw_tab;    // either slot rewrites an in-flight rd
    logic      raw_pair;   // dependency between the two slots
    logic      waw_pair;

    assign s1_rs1_chk = slot1_i.valid && (slot1_i.rs1 != REG_X0);
    assign s1_rs2_chk = slot1_i.valid && (slot1_i.rs2 != REG_X0);
    assign s1_rd_chk  = slot1_i.valid && slot1_i.rd_we && (slot1_i.rd != REG_X0);
    assign s2_rs1_chk = slot2_i.valid && (slot2_i.rs1 != REG_X0);
    assign s2_rs2_chk = slot2_i.valid && (slot2_i.rs2 != REG_X0);
    assign s2_rd_chk  = slot2_i.valid && slot2_i.rd_we && (slot2_i.rd != REG_X0);

    // retiring entry has its result ready, so it no longer blocks
    always_comb begin
        live = mask_i;
        if (commit_i.valid) begin
            live[commit_i.id] = 1'b0;
        end
    end

    // compare every source and written dest against each live entry
    always_comb begin
        raw_tab = 1'b0;
        waw_tab = 1'b0;
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (live[i]) begin
                if ((s1_rs1_chk && (slot1_i.rs1 == rd_tab_i[i])) ||
                    (s1_rs2_chk && (slot1_i.rs2 == rd_tab_i[i]))) begin
                    raw_tab = 1'b1;
                end
                if ((s2_rs1_chk && (slot2_i.rs1 == rd_tab_i[i])) ||
                    (s2_rs2_chk && (slot2_i.rs2 == rd_tab_i[i]))) begin
                    raw_tab = 1'b1;
                end
                if ((s1_rd_chk && (slot1_i.rd == rd_tab_i[i])) ||
                    (s2_rd_chk && (slot2_i.rd == rd_tab_i[i]))) begin
                    waw_tab = 1'b1;
                end
            end
        end
    end

    // inside the pair, checked in both directions
    // the _chk terms already imply both slots valid
    always_comb begin
        raw_pair = 1'b0;
        if (s2_rd_chk && ((s1_rs1_chk && (slot1_i.rs1 == slot2_i.rd)) ||
                          (s1_rs2_chk && (slot1_i.rs2 == slot2_i.rd)))) begin
            raw_pair = 1'b1;  // slot 1 reads what slot 2 writes
        end
        if (s1_rd_chk && ((s2_rs1_chk && (slot2_i.rs1 == slot1_i.rd)) ||
                          (s2_rs2_chk && (slot2_i.rs2 == slot1_i.rd)))) begin
            raw_pair = 1'b1;  // slot 2 reads what slot 1 writes
        end
    end

    assign waw_pair = s1_rd_chk && s2_rd_chk && (slot1_i.rd == slot2_i.rd);

    assign verdict_o = hazard_t'{raw: raw_tab | raw_pair, waw: waw_tab | waw_pair};

endmodule

// File: verilog/lsb_pkg.sv
package lsb_pkg;

    import isa_pkg::*;

    // in-flight long instruction table
    localparam int LSB_DEPTH       = 8;
    localparam int COMMIT_ID_WIDTH = $clog2(LSB_DEPTH);

    // occupancy counter has to hold the value LSB_DEPTH itself
    localparam int OCC_WIDTH = $clog2(LSB_DEPTH + 1);

    // most entries in use that still leave room for a full issue pair
    localparam int TWO_OK_MAX = LSB_DEPTH - 2;

    typedef logic [COMMIT_ID_WIDTH-1:0] commit_id_t;  // table index, doubles as commit id
    typedef logic [LSB_DEPTH-1:0]       lsb_mask_t;   // one valid bit per entry

    // destination register of every entry, indexed by commit id
    typedef reg_addr_t [LSB_DEPTH-1:0] rd_tab_t;

    // completion strobe from the divider / load unit
    typedef struct packed {
        logic       valid;  // one cycle pulse
        commit_id_t id;     // entry that retires
    } commit_t;

    // verdict for the pair currently at issue
    typedef struct packed {
        logic raw;  // true dependency, stalls
        logic waw;  // output dependency, flag only
    } hazard_t;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

    // register file geometry, rv32 has 32 integer registers
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // x0 reads as zero and never carries a dependency
    localparam reg_addr_t REG_X0 = '0;

    // one decoded instruction as seen by the scoreboard
    typedef struct packed {
        logic      valid;  // slot holds an instruction this cycle
        logic      rd_we;  // writes rd
        reg_addr_t rd;     // destination
        reg_addr_t rs1;    // first source
        reg_addr_t rs2;    // second source
    } issue_slot_t;

endpackage
